// File: cpsKey_macros.svh
/*
 * CPS2 key loader constants
 * frame length, register widths and table size shared by RTL and testbench
 */
`ifndef CPS_KEY_MACROS_SVH
`define CPS_KEY_MACROS_SVH

// bytes in one key frame from the host
`define CPS_KEY_BYTES 20

// raw shift register, 20 bytes
`define CPS_RAW_W 160

// decryption key, fields 7 6 9 8
`define CPS_KEY_W 64

// running board checksum
`define CPS_SUM_W 12

// 68000 word address, A23..A1
`define CPS_ADDR_W 23

// entries in the known board sum table
`define CPS_KNOWN_N 16

`endif

// File: cpsKeyPkg.sv
/*
 * CPS2 key types
 * vector typedefs for the key path and the table of known board checksums
 */
`default_nettype none

`include "cpsKey_macros.svh"

package cpsKeyPkg;

    typedef logic [7:0]               keyByte_t;  // host config byte
    typedef logic [`CPS_RAW_W-1:0]    rawKey_t;   // shifted-in frame
    typedef logic [`CPS_KEY_W-1:0]    cpsKey_t;   // unscrambled key
    typedef logic [15:0]              addrRng_t;  // upper limit, A23..A8 units
    typedef logic [`CPS_SUM_W-1:0]    keySum_t;   // board checksum
    typedef logic [`CPS_ADDR_W-1:0]   romAddr_t;  // cpu word address
    typedef logic [15:0]              romWord_t;  // program word
    typedef logic [4:0]               byteCnt_t;  // 0..20 bytes loaded

    // sums seen on real boards, first entries of the game list
    localparam keySum_t knownSums [`CPS_KNOWN_N] = '{
        12'h4C7, 12'hE81, 12'hFC6, 12'h0CA,
        12'h204, 12'hF12, 12'h03D, 12'hEE2,
        12'h247, 12'h147, 12'h16A, 12'h08A,
        12'h03B, 12'hDC6, 12'hF79, 12'h1C1
    };

endpackage

`default_nettype wire

// File: cpsKeyLoad.sv
/*
 * CPS2 key loader
 * detects host write edges, shifts bytes into the raw frame register,
 * counts the frame and unscrambles the key and address limit
 */
`timescale 1ns/1ps
`default_nettype none

`include "cpsKey_macros.svh"

module cpsKeyLoad import cpsKeyPkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire keyByte_t keyByte,
    input  wire logic     keyWe,
    output logic          byteStb,
    output keyByte_t      loadByte,
    output logic          keyFull,
    output cpsKey_t       key,
    output addrRng_t      addrRng
);

    logic     weLast;   // keyWe one cycle ago
    logic     weRise;   // host write edge
    rawKey_t  raw;      // newest byte at the top
    byteCnt_t cnt;      // bytes in current frame

    // one 16-bit config field, MSB first
    // bits 16k+10..15, then 16k..16k+7, then the two bits below the field
    function automatic logic [15:0] unField(rawKey_t r, int k);
        logic [15:0] f;
        int          base;
        base = 16 * k;
        for (int b = 0; b < 6; b++) begin
            f[15-b] = r[base+10+b];
        end
        for (int b = 0; b < 8; b++) begin
            f[9-b] = r[base+b];
        end
        f[1] = r[(base + `CPS_RAW_W - 8) % `CPS_RAW_W];  // field 0 wraps to 152
        f[0] = r[(base + `CPS_RAW_W - 7) % `CPS_RAW_W];  // and 153
        return f;
    endfunction

    assign weRise  = keyWe & ~weLast;
    assign keyFull = (cnt == byteCnt_t'(`CPS_KEY_BYTES));

    // edge detect stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            weLast  <= 1'b0;
            byteStb <= 1'b0;
        end else begin
            weLast  <= keyWe;
            byteStb <= weRise;  // one pulse per host write
        end
    end

    always_ff @(posedge clk) begin
        if (weRise) begin
            loadByte <= keyByte;  // held beside byteStb
        end
    end

    // store stage, a byte on a full frame opens a new frame
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raw <= '0;
            cnt <= '0;
        end else if (byteStb) begin
            raw <= {loadByte, raw[`CPS_RAW_W-1:8]};  // enter at top, shift down
            if (keyFull) begin
                cnt <= byteCnt_t'(1);
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // config word order is 0 1 2 3 4 5 7 6 9 8, only 0 and 6..9 are used
    assign addrRng = unField(raw, 0);
    assign key     = {unField(raw, 7), unField(raw, 6), unField(raw, 9), unField(raw, 8)};

    aCntMax: assert property (@(posedge clk) disable iff (rst)
        cnt <= byteCnt_t'(`CPS_KEY_BYTES))
        else $error("key byte count above frame length");

endmodule

`default_nettype wire

// File: cpsKeyCheck.sv
/*
 * CPS2 board checksum
 * running 12-bit sum of the key bytes, matched against the known board sums
 */
`timescale 1ns/1ps
`default_nettype none

`include "cpsKey_macros.svh"

module cpsKeyCheck import cpsKeyPkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     byteStb,
    input  wire keyByte_t loadByte,
    input  wire logic     keyFull,
    output logic          keyOk
);

    keySum_t sum;     // sum of current frame
    keySum_t sumBase; // start value for this byte
    logic    sumHit;  // sum is a known board

    // xor 065 first unless only bits 5:4 are set, then add signed byte
    function automatic keySum_t nextSum(keySum_t s, keyByte_t b);
        keySum_t t;
        t = s;
        if ((b & 8'hCF) != 8'h00) begin
            t = t ^ keySum_t'(12'h065);
        end
        return t + {{(`CPS_SUM_W-8){b[7]}}, b};  // mod 4096
    endfunction

    assign sumBase = keyFull ? '0 : sum;  // full frame, next byte restarts

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sum <= '0;
        end else if (byteStb) begin
            sum <= nextSum(sumBase, loadByte);
        end
    end

    // parallel compare against the table
    always_comb begin
        sumHit = 1'b0;
        for (int i = 0; i < `CPS_KNOWN_N; i++) begin
            if (sum == knownSums[i]) begin
                sumHit = 1'b1;
            end
        end
    end

    // a byte in flight moves sum and count, hold keyOk low for it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            keyOk <= 1'b0;
        end else begin
            keyOk <= keyFull & sumHit & ~byteStb;
        end
    end

    // keyFull comes from the loader, keyOk must never lead it
    aOkFull: assert property (@(posedge clk) disable iff (rst) keyOk |-> keyFull)
        else $error("keyOk high without a full key frame");

endmodule

`default_nettype wire

// File: cpsOpDecrypt.sv
/*
 * CPS2 opcode decryptor
 * checks the fetch against the address limit, XORs an address-rotated
 * key slice onto the word and registers it with its valid
 */
`timescale 1ns/1ps
`default_nettype none

`include "cpsKey_macros.svh"

module cpsOpDecrypt import cpsKeyPkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire romAddr_t fetchAddr,
    input  wire logic     fetchValid,
    input  wire romWord_t encWord,
    input  wire cpsKey_t  key,
    input  wire addrRng_t addrRng,
    input  wire logic     keyOk,
    output romWord_t      decWord,
    output logic          decValid
);

    logic        inRange;  // word is encrypted
    logic [1:0]  sliceSel; // key slice, 0 is key[15:0]
    logic [3:0]  rotAmt;   // left rotate amount
    romWord_t    slice;
    logic [31:0] rotDbl;   // doubled slice for rotate
    romWord_t    mask;
    romWord_t    plain;

    assign sliceSel = fetchAddr[1:0];
    assign rotAmt   = fetchAddr[5:2];

    // limit is compared on A23..A8, i.e. word address bits 22:7
    assign inRange = keyOk && (fetchAddr[`CPS_ADDR_W-1:7] < addrRng);

    assign slice  = key[16*sliceSel +: 16];
    assign rotDbl = {slice, slice} << rotAmt;
    assign mask   = rotDbl[31:16];  // slice rotated left

    assign plain = inRange ? (encWord ^ mask) : encWord;  // unknown board passes through

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            decValid <= 1'b0;
        end else begin
            decValid <= fetchValid;  // fixed one cycle latency
        end
    end

    always_ff @(posedge clk) begin
        if (fetchValid) begin
            decWord <= plain;
        end
    end

    aValidLat: assert property (@(posedge clk) disable iff (rst) fetchValid |=> decValid)
        else $error("decValid missing one cycle after fetchValid");

    aValidSrc: assert property (@(posedge clk) disable iff (rst)
        decValid |-> $past(fetchValid))
        else $error("decValid without a fetch one cycle before");

endmodule

`default_nettype wire

// File: cpsKeyTop.sv
/*
 * CPS2 key loader and opcode decryptor top
 * connects key loading, board check and word decryption
 */
`timescale 1ns/1ps
`default_nettype none

module cpsKeyTop import cpsKeyPkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire keyByte_t keyByte,
    input  wire logic     keyWe,
    input  wire romAddr_t fetchAddr,
    input  wire logic     fetchValid,
    input  wire romWord_t encWord,
    output romWord_t      decWord,
    output logic          decValid,
    output logic          keyOk,
    output addrRng_t      addrRng
);

    logic     byteStb;  // one pulse per host byte
    keyByte_t loadByte;
    logic     keyFull;  // 20 bytes in frame
    cpsKey_t  key;

    cpsKeyLoad i_cpsKeyLoad (
        .clk, .rst, .keyByte, .keyWe,
        .byteStb, .loadByte, .keyFull, .key, .addrRng
    );

    cpsKeyCheck i_cpsKeyCheck (
        .clk, .rst, .byteStb, .loadByte, .keyFull, .keyOk
    );

    cpsOpDecrypt i_cpsOpDecrypt (
        .clk, .rst, .fetchAddr, .fetchValid, .encWord,
        .key, .addrRng, .keyOk, .decWord, .decValid
    );

endmodule

`default_nettype wire

// File: tbCpsKey.sv
/*
 * CPS2 key loader testbench
 * loads random key frames, checks board sum, address limit and
 * opcode decryption against reference models
 */
`timescale 1ns/1ps
`default_nettype none

`include "cpsKey_macros.svh"

module tbCpsKey import cpsKeyPkg::*;;

    localparam int TIMEOUT = 5 * `CPS_KEY_BYTES * 4 + 1000 + 2000;  // loads, fetches, margin
    localparam int LAST = `CPS_KEY_BYTES - 1;

    logic     clk;
    logic     rst;
    keyByte_t keyByte;
    logic     keyWe;
    romAddr_t fetchAddr;
    logic     fetchValid;
    romWord_t encWord;
    romWord_t decWord;
    logic     decValid;
    logic     keyOk;
    addrRng_t addrRng;

    keyByte_t frame [`CPS_KEY_BYTES];  // byte 0 is sent first
    romWord_t expQ [$];                // expected words in fetch order
    addrRng_t refRng;
    cpsKey_t  refKey;
    logic     refOk;
    logic     lastFv;                  // fetchValid at previous negedge
    int       valErrs = 0;
    int       otherErrs = 0;
    int       cycles = 0;

    // source offset inside field k, MSB first, negative reaches the field below
    int fieldOfs [16] = '{10, 11, 12, 13, 14, 15, 0, 1, 2, 3, 4, 5, 6, 7, -8, -7};

    cpsKeyTop i_cpsKeyTop (
        .clk, .rst, .keyByte, .keyWe, .fetchAddr, .fetchValid, .encWord,
        .decWord, .decValid, .keyOk, .addrRng
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic keySum_t refSum();
        keySum_t s;
        s = '0;
        for (int i = 0; i < `CPS_KEY_BYTES; i++) begin
            if ((frame[i] & 8'hCF) != 8'h00) s = s ^ 12'h065;
            s = s + keySum_t'($signed(frame[i]));  // sign extend, wraps at 4096
        end
        return s;
    endfunction

    function automatic logic isKnown(keySum_t s);
        for (int i = 0; i < `CPS_KNOWN_N; i++) begin
            if (knownSums[i] == s) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic [15:0] refField(rawKey_t r, int k);
        logic [15:0] f;
        for (int j = 0; j < 16; j++) begin
            f[15-j] = r[(16 * k + fieldOfs[j] + `CPS_RAW_W) % `CPS_RAW_W];
        end
        return f;
    endfunction

    function automatic romWord_t refDecrypt(romAddr_t a, romWord_t w);
        logic [15:0] m;
        if (!refOk || a[22:7] >= refRng) return w;  // unknown board or above limit
        m = refKey[16 * a[1:0] +: 16];
        for (int i = 0; i < a[5:2]; i++) begin
            m = {m[14:0], m[15]};  // rotate left one
        end
        return w ^ m;
    endfunction

    task automatic checkWord(string name, romWord_t got, romWord_t exp);
        if (got !== exp) begin
            valErrs++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkRng(string name, addrRng_t got, addrRng_t exp);
        if (got !== exp) begin
            valErrs++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            valErrs++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    // 19 random bytes, last byte searched for a known sum or kept off the table
    task automatic makeFrame(logic wantHit);
        logic done;
        done = 1'b0;
        while (!done) begin
            for (int i = 0; i < LAST; i++) frame[i] = keyByte_t'($urandom);
            if (wantHit) begin
                for (int v = 0; v < 256 && !done; v++) begin
                    frame[LAST] = keyByte_t'(v);
                    done = isKnown(refSum());
                end
            end else begin
                frame[LAST] = keyByte_t'($urandom);
                done = !isKnown(refSum());
            end
        end
    endtask

    // keyWe high 2 cycles, low 2, optional keyOk watch after the edge
    task automatic writeByte(keyByte_t b, logic watch);
        @(posedge clk);
        keyByte <= b;
        keyWe   <= 1'b1;
        for (int c = 1; c <= 3; c++) begin
            @(posedge clk);
            if (c == 2) keyWe <= 1'b0;
            if (watch) begin
                @(negedge clk);
                checkFlag("keyOk", keyOk, (c == 3) ? refOk : 1'b0);  // rises on 3rd edge
            end
        end
    endtask

    task automatic loadFrame(logic watch);
        rawKey_t r;
        for (int i = 0; i < `CPS_KEY_BYTES; i++) r[8*i +: 8] = frame[i];
        refRng = refField(r, 0);
        refKey = {refField(r, 7), refField(r, 6), refField(r, 9), refField(r, 8)};
        refOk  = isKnown(refSum());
        for (int i = 0; i < `CPS_KEY_BYTES; i++) writeByte(frame[i], watch && (i == LAST));
        @(negedge clk);
        checkFlag("keyOk", keyOk, refOk);
        checkRng("addrRng", addrRng, refRng);
    endtask

    // back to back fetches, limit picks half inside, half above addrRng
    task automatic runFetches(int n, logic mix);
        romAddr_t a;
        romWord_t w;
        logic [15:0] hi;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            a  = romAddr_t'($urandom);
            w  = romWord_t'($urandom);
            hi = a[22:7];
            if (mix && refRng != 0 && $urandom % 2) begin
                hi = 16'($urandom % refRng);
            end else if (mix) begin
                hi = 16'(refRng + $urandom % (65536 - int'(refRng)));
            end
            a = {hi, a[6:0]};
            fetchAddr  <= a;
            encWord    <= w;
            fetchValid <= 1'b1;
            expQ.push_back(refDecrypt(a, w));
        end
        @(posedge clk);
        fetchValid <= 1'b0;
    endtask

    task automatic pulseReset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (10) @(posedge clk);
        rst    <= 1'b0;
        refRng = '0;  // raw register cleared
        refKey = '0;
        refOk  = 1'b0;
        @(negedge clk);
        checkFlag("keyOk", keyOk, 1'b0);
        checkRng("addrRng", addrRng, 16'h0000);
    endtask

    // compare process, outputs are sampled between edges
    always @(negedge clk) begin
        romWord_t exp;
        if (!rst) begin
            if (decValid !== lastFv) begin
                otherErrs++;
                $display("decValid did not follow fetchValid by one cycle at %0t", $time);
            end
            if (decValid === 1'b1) begin
                if (expQ.size() == 0) begin
                    otherErrs++;
                    $display("decValid seen with no fetch pending at %0t", $time);
                end else begin
                    exp = expQ.pop_front();
                    checkWord("decWord", decWord, exp);
                end
            end
        end
        lastFv = fetchValid;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("run stopped by timeout after %0d cycles", cycles);
            $display("value errors %0d, other errors %0d", valErrs, otherErrs + 1);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        void'($urandom(75));
        rst        = 1'b1;
        keyByte    = '0;
        keyWe      = 1'b0;
        fetchAddr  = '0;
        fetchValid = 1'b0;
        encWord    = '0;
        refRng     = '0;
        refKey     = '0;
        refOk      = 1'b0;
        lastFv     = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkFlag("keyOk", keyOk, 1'b0);       // nothing loaded yet
        checkRng("addrRng", addrRng, 16'h0000);
        runFetches(16, 1'b0);
        makeFrame(1'b0);                       // sum off the table
        loadFrame(1'b0);
        runFetches(16, 1'b0);
        makeFrame(1'b1);                       // known board
        loadFrame(1'b1);
        runFetches(300, 1'b1);
        makeFrame(1'b1);                       // reload over a valid key
        loadFrame(1'b1);
        runFetches(200, 1'b1);
        makeFrame(1'b1);
        for (int i = 0; i < 10; i++) writeByte(frame[i], 1'b0);  // half a frame
        pulseReset();
        runFetches(16, 1'b1);
        makeFrame(1'b1);
        loadFrame(1'b1);
        runFetches(50, 1'b1);
        wait (expQ.size() == 0);
        repeat (2) @(negedge clk);
        $display("value errors %0d, other errors %0d", valErrs, otherErrs);
        if (valErrs + otherErrs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
cpsKeyPkg.sv
cpsKeyLoad.sv
cpsKeyCheck.sv
cpsOpDecrypt.sv
cpsKeyTop.sv
tbCpsKey.sv

// File: Bender.yml
package:
  name: cps_key

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cpsKeyPkg.sv
      - cpsKeyLoad.sv
      - cpsKeyCheck.sv
      - cpsOpDecrypt.sv
      - cpsKeyTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbCpsKey.sv
